// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 -Wno-fatal
TOP       := tb_branch_unit
FILELIST  := branch_unit.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := all tests passed
SRCS      := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code does not
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "brat_macros.svh"

module tb_branch_unit;

    localparam int            LANES      = `BRAT_LANES;
    localparam int            WAIT_LIMIT = 60;
    localparam brat_pkg::pc_t PC_A       = 32'h0000_0340;

    typedef struct packed {
        brat_pkg::tag_t tag;
        brat_pkg::pc_t  pc;
        logic           pred;
        logic           done;
        logic           taken;
        brat_pkg::pc_t  target;
    } entry_t;

    logic             clk;
    logic             rst_n;
    logic             alloc_valid;
    brat_pkg::pc_t    alloc_pc;
    logic             alloc_ready;
    brat_pkg::tag_t   alloc_tag;
    logic             pred_taken;
    logic [LANES-1:0] exec_valid;
    brat_pkg::tag_t   exec_tag [LANES];
    logic [LANES-1:0] exec_taken;
    brat_pkg::pc_t    exec_target [LANES];
    logic [LANES-1:0] release_valid;
    brat_pkg::tag_t   release_tag [LANES];
    logic             redirect_valid;
    brat_pkg::pc_t    redirect_pc;

    // Reference model with pending entries oldest first and counters as 0 to 3
    entry_t         model_q [$];
    int             ctr_model [64];
    brat_pkg::tag_t model_tail;

    string       test_name = "reset";
    int          checks_done;
    int          value_errors;
    int          timeout_errors;
    logic [31:0] lfsr_state = 32'h44fcdf53;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    branch_unit u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .alloc_valid_i    (alloc_valid),
        .alloc_pc_i       (alloc_pc),
        .alloc_ready_o    (alloc_ready),
        .alloc_tag_o      (alloc_tag),
        .pred_taken_o     (pred_taken),
        .exec_valid_i     (exec_valid),
        .exec_tag_i       (exec_tag),
        .exec_taken_i     (exec_taken),
        .exec_target_i    (exec_target),
        .release_valid_o  (release_valid),
        .release_tag_o    (release_tag),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    // ==================================================
    // Reference model and compare
    // ==================================================

    function automatic int ctr_index(input brat_pkg::pc_t pc);
        return int'(pc[7:2]);
    endfunction

    function automatic int step_ctr(input int c, input logic taken);
        if (taken) begin
            return (c == 3) ? 3 : c + 1;
        end
        return (c == 0) ? 0 : c - 1;
    endfunction

    // Length of the oldest done run up to and including the first wrong guess
    function automatic int expected_run(output logic redir, output brat_pkg::pc_t rpc);
        int     n;
        logic   stop;
        entry_t e;
        n     = 0;
        stop  = 1'b0;
        redir = 1'b0;
        rpc   = '0;
        while (n < LANES && n < model_q.size() && !stop) begin
            e = model_q[n];
            if (!e.done) begin
                stop = 1'b1;
            end else begin
                n++;
                if (e.taken != e.pred) begin
                    redir = 1'b1;
                    rpc   = e.taken ? e.target : e.pc + 32'd4;
                    stop  = 1'b1;
                end
            end
        end
        return n;
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks_done++;
        if (act !== exp) begin
            $display("FAILED %s: %s expected %0b actual %0b", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_tag(input string what, input brat_pkg::tag_t exp,
                             input brat_pkg::tag_t act);
        checks_done++;
        if (act !== exp) begin
            $display("FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pc(input string what, input brat_pkg::pc_t exp,
                            input brat_pkg::pc_t act);
        checks_done++;
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    // Checks outputs mid-cycle and then moves the model across the coming edge
    task automatic compare_cycle();
        int            n;
        logic          redir;
        logic          ready;
        logic          pred;
        brat_pkg::pc_t rpc;
        entry_t        e;
        n     = expected_run(redir, rpc);
        ready = (model_q.size() < `BRAT_DEPTH) && !redir;
        pred  = ctr_model[ctr_index(alloc_pc)] >= 2;
        for (int l = 0; l < LANES; l++) begin
            check_bit($sformatf("release_valid[%0d]", l), l < n, release_valid[l]);
            if (l < n) begin
                e = model_q[l];
                check_tag($sformatf("release_tag[%0d]", l), e.tag, release_tag[l]);
            end
        end
        check_bit("redirect_valid", redir, redirect_valid);
        if (redir) begin
            check_pc("redirect_pc", rpc, redirect_pc);
        end
        check_bit("alloc_ready", ready, alloc_ready);
        check_tag("alloc_tag", model_tail, alloc_tag);
        check_bit("pred_taken", pred, pred_taken);
        for (int l = 0; l < n; l++) begin
            e = model_q.pop_front();
            ctr_model[ctr_index(e.pc)] = step_ctr(ctr_model[ctr_index(e.pc)], e.taken);
        end
        if (redir) begin
            model_q.delete();
        end else begin
            for (int l = 0; l < LANES; l++) begin
                for (int i = 0; i < model_q.size(); i++) begin
                    e = model_q[i];
                    if (exec_valid[l] && e.tag == exec_tag[l] && !e.done) begin
                        e.done      = 1'b1;
                        e.taken     = exec_taken[l];
                        e.target    = exec_target[l];
                        model_q[i]  = e;
                    end
                end
            end
            if (alloc_valid && ready) begin
                e        = '0;
                e.tag    = model_tail;
                e.pc     = alloc_pc;
                e.pred   = pred;
                model_q.push_back(e);
                model_tail = model_tail + 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            compare_cycle();
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
        alloc_valid = 1'b0;
        exec_valid  = '0;
    endtask

    task automatic set_result(input int lane, input brat_pkg::tag_t tag, input logic taken,
                              input brat_pkg::pc_t target);
        exec_valid[lane]  = 1'b1;
        exec_tag[lane]    = tag;
        exec_taken[lane]  = taken;
        exec_target[lane] = target;
    endtask

    // Holds the request until the table has room
    task automatic alloc_branch(input brat_pkg::pc_t pc, output brat_pkg::tag_t tag);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        tag      = '0;
        while (!accepted && waited < WAIT_LIMIT) begin
            alloc_valid = 1'b1;
            alloc_pc    = pc;
            @(negedge clk);
            accepted = alloc_ready;
            tag      = alloc_tag;
            tick();
            waited++;
        end
        if (!accepted) begin
            $display("Timeout in %s: allocation of pc %h was never accepted", test_name, pc);
            timeout_errors++;
        end
    endtask

    task automatic wait_release(input brat_pkg::tag_t tag);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                if (release_valid[l] && release_tag[l] == tag) begin
                    seen = 1'b1;
                end
            end
            tick();
            waited++;
        end
        if (!seen) begin
            $display("Timeout in %s: tag %0d was never released", test_name, tag);
            timeout_errors++;
        end
    endtask

    task automatic wait_redirect(output brat_pkg::pc_t pc);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        pc     = '0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            seen = redirect_valid;
            pc   = redirect_pc;
            tick();
            waited++;
        end
        if (!seen) begin
            $display("Timeout in %s: no redirect was raised", test_name);
            timeout_errors++;
        end
    endtask

    task automatic check_pred(input brat_pkg::pc_t pc, input logic exp, input string what);
        alloc_pc = pc;
        @(negedge clk);
        check_bit(what, exp, pred_taken);
        tick();
    endtask

    task automatic resolve_one(input brat_pkg::pc_t pc, input logic taken);
        brat_pkg::tag_t tag;
        alloc_branch(pc, tag);
        set_result(0, tag, taken, 32'h0000_3000);
        tick();
        wait_release(tag);
    endtask

    // Resolves everything pending as predicted so that no flush happens
    task automatic drain_all();
        int     waited;
        int     lane;
        entry_t e;
        waited = 0;
        while (model_q.size() != 0 && waited < WAIT_LIMIT) begin
            lane = 0;
            for (int i = 0; i < model_q.size(); i++) begin
                e = model_q[i];
                if (!e.done && lane < LANES) begin
                    set_result(lane, e.tag, e.pred, 32'h0000_0800);
                    lane++;
                end
            end
            tick();
            waited++;
        end
        if (model_q.size() != 0) begin
            $display("Timeout in %s: pending branches did not drain", test_name);
            timeout_errors++;
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        brat_pkg::tag_t tags [8];
        brat_pkg::tag_t tag;
        brat_pkg::pc_t  seen_pc;
        entry_t         e;
        logic [7:0]     used;
        int             pick;
        int             waited;
        alloc_valid = 1'b0;
        alloc_pc    = '0;
        exec_valid  = '0;
        exec_taken  = '0;
        for (int l = 0; l < LANES; l++) begin
            exec_tag[l]    = '0;
            exec_target[l] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ctr_model[i] = 1;
        end
        model_tail     = '0;
        checks_done    = 0;
        value_errors   = 0;
        timeout_errors = 0;
        waited         = 0;
        while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeout_errors++;
        end

        for (int i = 0; i < 8; i++) begin
            check_pred(32'h0000_0100 + 32'(i * 36), 1'b0, "pred_taken after reset");
        end

        test_name = "reverse order";
        for (int i = 0; i < 6; i++) begin
            alloc_branch(32'h0000_0200 + 32'(4 * i), tags[i]);
        end
        for (int i = 5; i >= 0; i--) begin
            set_result(0, tags[i], 1'b0, '0);
            tick();
        end
        wait_release(tags[5]);

        test_name = "training";
        resolve_one(PC_A, 1'b1);
        resolve_one(PC_A, 1'b1);
        check_pred(PC_A, 1'b1, "pred_taken after two taken");
        resolve_one(PC_A, 1'b0);
        check_pred(PC_A, 1'b1, "pred_taken after one not-taken");
        resolve_one(PC_A, 1'b0);
        check_pred(PC_A, 1'b0, "pred_taken after two not-taken");
        // Three releases on one counter walk it from weak_nt to strong_nt and back to weak_nt
        for (int i = 0; i < 3; i++) begin
            alloc_branch(PC_A + 32'(i * 256), tags[i]);
        end
        set_result(0, tags[0], 1'b0, '0);
        set_result(1, tags[1], 1'b0, '0);
        set_result(2, tags[2], 1'b1, 32'h0000_3100);
        tick();
        wait_release(tags[2]);
        resolve_one(PC_A, 1'b1);
        check_pred(PC_A, 1'b1, "pred_taken after same index releases");

        test_name = "mispredict";
        for (int i = 0; i < 5; i++) begin
            alloc_branch(32'h0000_05c0 + 32'(4 * i), tags[i]);
        end
        set_result(0, tags[2], 1'b0, '0);
        set_result(1, tags[1], 1'b1, 32'h0000_9000);
        set_result(2, tags[0], 1'b0, '0);
        tick();
        set_result(0, tags[3], 1'b0, '0);
        set_result(1, tags[4], 1'b0, '0);
        wait_redirect(seen_pc);
        check_pc("redirect_pc on taken mispredict", 32'h0000_9000, seen_pc);
        repeat (3) tick();
        alloc_branch(32'h0000_0600, tag);
        check_tag("tag after flush", tags[4] + 1'b1, tag);
        drain_all();

        test_name = "back-pressure";
        for (int i = 0; i < 8; i++) begin
            alloc_branch(32'h0000_0700 + 32'(4 * i), tags[i]);
        end
        alloc_valid = 1'b1;
        alloc_pc    = 32'h0000_0740;
        repeat (3) begin
            @(negedge clk);
            check_bit("alloc_ready when full", 1'b0, alloc_ready);
            @(posedge clk);
            #2;
        end
        e = model_q[0];
        set_result(0, e.tag, e.pred, 32'h0000_0800);
        alloc_branch(32'h0000_0740, tag);
        check_tag("tag after back-pressure", tags[0], tag);
        drain_all();

        test_name = "random";
        for (int c = 0; c < 300; c++) begin
            alloc_valid = rand_bits(2) != 0;
            alloc_pc    = 32'h0000_1000 + (brat_pkg::pc_t'(rand_bits(4)) << 2);
            used        = '0;
            for (int l = 0; l < LANES; l++) begin
                if (rand_bits(1) == 1 && model_q.size() != 0) begin
                    pick = int'(rand_bits(3)) % model_q.size();
                    e    = model_q[pick];
                    if (!e.done && !used[e.tag]) begin
                        used[e.tag] = 1'b1;
                        // About one result in four goes against the guess
                        set_result(l, e.tag, (rand_bits(2) == 0) ? !e.pred : e.pred,
                                   32'h0000_8000 + (brat_pkg::pc_t'(rand_bits(6)) << 2));
                    end
                end
            end
            tick();
        end
        drain_all();

        $display("Closing: %0d checks, %0d value errors, %0d timeouts",
                 checks_done, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset held over the first 4 rising edges, released just after the last
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: branch_unit.f
+incdir+verilog
verilog/brat_pkg.sv
verilog/bimodal_predictor.sv
verilog/branch_table.sv
verilog/branch_unit.sv
bench/tb_clock_gen.sv
bench/tb_branch_unit.sv

// File: verilog/bimodal_predictor.sv
`timescale 1ns/100ps
`default_nettype none

`include "brat_macros.svh"

module bimodal_predictor (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Lookup for the branch being allocated
    input  brat_pkg::pc_t          lookup_pc_i,
    output logic                   pred_taken_o,

    // Training from released branches, lane 0 is the oldest
    input  logic [`BRAT_LANES-1:0] train_valid_i,
    input  brat_pkg::pc_t          train_pc_i [`BRAT_LANES],
    input  logic [`BRAT_LANES-1:0] train_taken_i
);

    localparam int unsigned NUM_CTRS = 1 << `BRAT_BP_IDX_W;

    brat_pkg::ctr_state_e ctr_q [NUM_CTRS];
    brat_pkg::ctr_state_e ctr_d [NUM_CTRS];
    brat_pkg::ctr_state_e lookup_ctr;

    // Word aligned PC selects the counter
    function automatic brat_pkg::bp_idx_t pc_to_idx(input brat_pkg::pc_t pc);
        return pc[`BRAT_BP_IDX_W+1:2];
    endfunction

    // One saturating step toward the outcome
    function automatic brat_pkg::ctr_state_e ctr_step(
        input brat_pkg::ctr_state_e cur,
        input logic                 taken
    );
        brat_pkg::ctr_state_e nxt;
        nxt = cur;
        case (cur)
            brat_pkg::strong_nt: nxt = taken ? brat_pkg::weak_nt  : brat_pkg::strong_nt;
            brat_pkg::weak_nt:   nxt = taken ? brat_pkg::weak_t   : brat_pkg::strong_nt;
            brat_pkg::weak_t:    nxt = taken ? brat_pkg::strong_t : brat_pkg::weak_nt;
            brat_pkg::strong_t:  nxt = taken ? brat_pkg::strong_t : brat_pkg::weak_t;
            default:             nxt = brat_pkg::weak_nt;
        endcase
        return nxt;
    endfunction

    // ==================================================
    // Lookup
    // ==================================================

    // Reads the registered counter, so same cycle training is not visible
    assign lookup_ctr   = ctr_q[pc_to_idx(lookup_pc_i)];
    assign pred_taken_o = (lookup_ctr == brat_pkg::weak_t) ||
                          (lookup_ctr == brat_pkg::strong_t);

    // ==================================================
    // Training
    // ==================================================

    // Lanes applied oldest first so hits on one index accumulate
    always_comb begin
        brat_pkg::bp_idx_t idx;
        ctr_d = ctr_q;
        for (int l = 0; l < `BRAT_LANES; l++) begin
            idx = pc_to_idx(train_pc_i[l]);
            if (train_valid_i[l]) begin
                ctr_d[idx] = ctr_step(ctr_d[idx], train_taken_i[l]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_CTRS; i++) begin
                ctr_q[i] <= brat_pkg::weak_nt;
            end
        end else begin
            for (int i = 0; i < NUM_CTRS; i++) begin
                ctr_q[i] <= ctr_d[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "brat_macros.svh"

module branch_table (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Allocation from fetch
    input  logic                   alloc_valid_i,
    input  brat_pkg::pc_t          alloc_pc_i,
    input  logic                   alloc_pred_i,
    output logic                   alloc_ready_o,
    output brat_pkg::tag_t         alloc_tag_o,

    // Results from the execute lanes, any order
    input  logic [`BRAT_LANES-1:0] exec_valid_i,
    input  brat_pkg::tag_t         exec_tag_i [`BRAT_LANES],
    input  logic [`BRAT_LANES-1:0] exec_taken_i,
    input  brat_pkg::pc_t          exec_target_i [`BRAT_LANES],

    // In-order release, bit 0 is the oldest
    output logic [`BRAT_LANES-1:0] release_valid_o,
    output brat_pkg::tag_t         release_tag_o [`BRAT_LANES],
    output brat_pkg::pc_t          release_pc_o [`BRAT_LANES],
    output logic [`BRAT_LANES-1:0] release_taken_o,

    // Eager flush on a released mispredict
    output logic                   redirect_valid_o,
    output brat_pkg::pc_t          redirect_pc_o
);

    typedef logic [`BRAT_TAG_W:0] count_t;

    // Control state
    brat_pkg::tag_t          head_q;
    brat_pkg::tag_t          tail_q;
    count_t                  count_q;
    logic [`BRAT_DEPTH-1:0]  valid_q;
    logic [`BRAT_DEPTH-1:0]  done_q;

    // Per-entry payload
    brat_pkg::pc_t           pc_q [`BRAT_DEPTH];
    logic [`BRAT_DEPTH-1:0]  pred_q;
    logic [`BRAT_DEPTH-1:0]  taken_q;
    brat_pkg::pc_t           target_q [`BRAT_DEPTH];

    logic                    alloc_fire;
    logic [`BRAT_LANES-1:0]  exec_hit;
    count_t                  rel_cnt;

    // ==================================================
    // Allocation
    // ==================================================

    // No room when full, and no new entries while flushing
    assign alloc_ready_o = (count_q != count_t'(`BRAT_DEPTH)) && !redirect_valid_o;
    assign alloc_fire    = alloc_valid_i && alloc_ready_o;
    assign alloc_tag_o   = tail_q;

    // ==================================================
    // Result capture
    // ==================================================

    // Only pending entries that are not yet done take a result
    always_comb begin
        for (int l = 0; l < `BRAT_LANES; l++) begin
            exec_hit[l] = exec_valid_i[l] &&
                          valid_q[exec_tag_i[l]] &&
                          !done_q[exec_tag_i[l]];
        end
    end

    // ==================================================
    // Release run and mispredict check
    // ==================================================

    always_comb begin
        brat_pkg::tag_t slot;
        logic           run_open;
        run_open         = 1'b1;
        release_valid_o  = '0;
        rel_cnt          = '0;
        redirect_valid_o = 1'b0;
        redirect_pc_o    = '0;
        for (int l = 0; l < `BRAT_LANES; l++) begin
            slot               = head_q + brat_pkg::tag_t'(l);
            release_tag_o[l]   = slot;
            release_pc_o[l]    = pc_q[slot];
            release_taken_o[l] = taken_q[slot];
            if (run_open && valid_q[slot] && done_q[slot]) begin
                release_valid_o[l] = 1'b1;
                rel_cnt            = rel_cnt + count_t'(1);
                // Run ends after the first wrong guess
                if (taken_q[slot] != pred_q[slot]) begin
                    redirect_valid_o = 1'b1;
                    redirect_pc_o    = taken_q[slot] ? target_q[slot]
                                                     : pc_q[slot] + brat_pkg::pc_t'(4);
                    run_open         = 1'b0;
                end
            end else begin
                run_open = 1'b0;
            end
        end
    end

    // ==================================================
    // Pointers and entry flags
    // ==================================================

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else if (redirect_valid_o) begin
            // Everything younger is discarded, tags continue from tail
            head_q  <= tail_q;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            for (int l = 0; l < `BRAT_LANES; l++) begin
                if (release_valid_o[l]) begin
                    valid_q[release_tag_o[l]] <= 1'b0;
                    done_q[release_tag_o[l]]  <= 1'b0;
                end
            end
            for (int l = 0; l < `BRAT_LANES; l++) begin
                if (exec_hit[l]) begin
                    done_q[exec_tag_i[l]] <= 1'b1;
                end
            end
            if (alloc_fire) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + brat_pkg::tag_t'(1);
            end
            head_q  <= head_q + brat_pkg::tag_t'(rel_cnt);
            count_q <= count_q + count_t'(alloc_fire) - rel_cnt;
        end
    end

    // Payload writes, qualified by the flags above
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pc_q[tail_q]   <= alloc_pc_i;
            pred_q[tail_q] <= alloc_pred_i;
        end
        for (int l = 0; l < `BRAT_LANES; l++) begin
            if (exec_hit[l]) begin
                taken_q[exec_tag_i[l]]  <= exec_taken_i[l];
                target_q[exec_tag_i[l]] <= exec_target_i[l];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "brat_macros.svh"

module branch_unit (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Fetch side
    input  logic                   alloc_valid_i,
    input  brat_pkg::pc_t          alloc_pc_i,
    output logic                   alloc_ready_o,
    output brat_pkg::tag_t         alloc_tag_o,
    output logic                   pred_taken_o,

    // Execute lanes
    input  logic [`BRAT_LANES-1:0] exec_valid_i,
    input  brat_pkg::tag_t         exec_tag_i [`BRAT_LANES],
    input  logic [`BRAT_LANES-1:0] exec_taken_i,
    input  brat_pkg::pc_t          exec_target_i [`BRAT_LANES],

    // Resolution and flush
    output logic [`BRAT_LANES-1:0] release_valid_o,
    output brat_pkg::tag_t         release_tag_o [`BRAT_LANES],
    output logic                   redirect_valid_o,
    output brat_pkg::pc_t          redirect_pc_o
);

    // Training path from table to predictor
    brat_pkg::pc_t          release_pc [`BRAT_LANES];
    logic [`BRAT_LANES-1:0] release_taken;

    // ==================================================
    // Bimodal predictor
    // ==================================================

    bimodal_predictor u_predictor (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lookup_pc_i   (alloc_pc_i),
        .pred_taken_o  (pred_taken_o),
        .train_valid_i (release_valid_o),
        .train_pc_i    (release_pc),
        .train_taken_i (release_taken)
    );

    // ==================================================
    // Branch resolution table
    // ==================================================

    branch_table u_table (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .alloc_valid_i    (alloc_valid_i),
        .alloc_pc_i       (alloc_pc_i),
        .alloc_pred_i     (pred_taken_o),
        .alloc_ready_o    (alloc_ready_o),
        .alloc_tag_o      (alloc_tag_o),
        .exec_valid_i     (exec_valid_i),
        .exec_tag_i       (exec_tag_i),
        .exec_taken_i     (exec_taken_i),
        .exec_target_i    (exec_target_i),
        .release_valid_o  (release_valid_o),
        .release_tag_o    (release_tag_o),
        .release_pc_o     (release_pc),
        .release_taken_o  (release_taken),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

`default_nettype wire

// File: verilog/brat_macros.svh
`ifndef BRAT_MACROS_SVH
`define BRAT_MACROS_SVH

// ==================================================
// Branch path sizing
// ==================================================

// Program counter width
`define BRAT_PC_W 32

// Pending branch entries, tag is log2 of this
`define BRAT_DEPTH 8
`define BRAT_TAG_W 3

// Execute lanes, also the release width
`define BRAT_LANES 3

// Counter index taken from PC bits 7 down to 2
`define BRAT_BP_IDX_W 6

`endif

// File: verilog/brat_pkg.sv
`default_nettype none

`include "brat_macros.svh"

package brat_pkg;

    typedef logic [`BRAT_PC_W-1:0]     pc_t;
    typedef logic [`BRAT_TAG_W-1:0]    tag_t;
    typedef logic [`BRAT_BP_IDX_W-1:0] bp_idx_t;

    // Two-bit saturating counter, upper half predicts taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_e;

endpackage

`default_nettype wire
